/* rtl/iso_defines.svh */
// Isolation bridge parameters
`ifndef ISO_DEFINES_SVH
`define ISO_DEFINES_SVH

// Requests a path may have in flight before upstream stalls
// Kept small so the limit is hit under random traffic
`define ISO_MAX_OUTSTANDING 4

// Address and transaction ID widths shared by AW and AR
`define ISO_ADDR_WIDTH 32
`define ISO_ID_WIDTH 4

// Read data beat width
`define ISO_DATA_WIDTH 32

// Burst length field, beats = len + 1, so 1 to 16
`define ISO_LEN_WIDTH 4

`endif

/* rtl/iso_pkg.sv */
// Isolation bridge payload types
`include "iso_defines.svh"

package iso_pkg;

  // Response code, same encoding as AXI BRESP/RRESP
  typedef logic [1:0] resp_t;

  // Write address request, 36 bits
  typedef struct packed {
    logic [`ISO_ADDR_WIDTH-1:0] addr;
    logic [`ISO_ID_WIDTH-1:0]   id;
  } aw_req_t;

  // Write response, 6 bits
  // Always a single beat
  typedef struct packed {
    logic [`ISO_ID_WIDTH-1:0] id;
    resp_t                    resp;
  } b_rsp_t;

  // Read address request, 40 bits
  // len counts beats minus one
  typedef struct packed {
    logic [`ISO_ADDR_WIDTH-1:0] addr;
    logic [`ISO_ID_WIDTH-1:0]   id;
    logic [`ISO_LEN_WIDTH-1:0]  len;
  } ar_req_t;

  // Read data beat, 38 bits
  // The last flag travels beside the payload on the channel
  typedef struct packed {
    logic [`ISO_DATA_WIDTH-1:0] data;
    logic [`ISO_ID_WIDTH-1:0]   id;
    resp_t                      resp;
  } r_rsp_t;

endpackage

/* rtl/iso_chan_if.sv */
// Request and response channel pair
`timescale 1ns/100ps

interface iso_chan_if #(
  parameter type req_t = logic,
  parameter type rsp_t = logic
);

  // Request direction, manager towards subordinate
  logic req_valid;
  logic req_ready;
  req_t req;

  // Response direction, subordinate towards manager
  logic rsp_valid;
  logic rsp_ready;
  rsp_t rsp;

  // Marks the final beat of a response burst
  logic rsp_last;

  // Tracker side facing the upstream manager
  // Tracker acts as the subordinate here
  modport up (
    input  req_valid,
    input  req,
    output req_ready,
    output rsp_valid,
    output rsp,
    output rsp_last,
    input  rsp_ready
  );

  // Tracker side facing the downstream subordinate
  // Tracker acts as the manager here
  modport dn (
    output req_valid,
    output req,
    input  req_ready,
    input  rsp_valid,
    input  rsp,
    input  rsp_last,
    output rsp_ready
  );

endinterface

/* rtl/outstanding_counter.sv */
// Outstanding transaction counter
`timescale 1ns/100ps

module outstanding_counter #(
  parameter int MaxValue = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          incr,
  input  logic                          decr,
  output logic [$clog2(MaxValue+1)-1:0] count,
  output logic                          full,
  output logic                          empty
);

  localparam int CountWidth = $clog2(MaxValue + 1);

  // Wide enough to hold MaxValue itself
  // No saturation, callers never push past the limit or below zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      // Simultaneous incr and decr cancel out
      if (incr && !decr) begin
        count <= count + 1'b1;
      end else if (decr && !incr) begin
        count <= count - 1'b1;
      end
    end
  end

  // Limit reached, caller must stop issuing
  assign full = (count == CountWidth'(MaxValue));

  // Nothing in flight
  assign empty = (count == '0);

endmodule

/* rtl/iso_req_tracker.sv */
// Per-path isolation request tracker
`timescale 1ns/100ps
`include "iso_defines.svh"

module iso_req_tracker #(
  parameter type req_t          = logic,
  parameter type rsp_t          = logic,
  parameter int  MaxOutstanding = `ISO_MAX_OUTSTANDING,
  parameter bit  MultiBeat      = 1'b1
) (
  input  logic       clk,
  input  logic       rst_n,
  iso_chan_if.up     up,
  iso_chan_if.dn     dn,
  input  logic       isolate_req,
  output logic       isolate_done
);

  localparam int CountWidth = $clog2(MaxOutstanding + 1);

  logic                  req_fire;
  logic                  rsp_fire;
  logic                  rsp_last;
  logic                  retire;
  logic                  count_full;
  logic [CountWidth-1:0] out_count;
  logic                  isolated;
  logic                  block_req;
  logic                  isolate_done_next;

  // Single-beat paths treat every response as the last one
  assign rsp_last = MultiBeat ? dn.rsp_last : 1'b1;

  // Request accepted downstream, one more response owed
  assign req_fire = dn.req_valid && dn.req_ready;

  // Any response beat taken from downstream, forwarded or dropped
  assign rsp_fire = dn.rsp_valid && dn.rsp_ready;

  // Final beat closes out one request
  assign retire = rsp_fire && rsp_last;

  outstanding_counter #(
    .MaxValue (MaxOutstanding)
  ) counter_i (
    .clk   (clk),
    .rst_n (rst_n),
    .incr  (req_fire),
    .decr  (retire),
    .count (out_count),
    .full  (count_full),
    .empty ()
  );

  // Blocking starts in the same cycle isolate_req goes high
  // and holds until the done register clears
  assign isolated = isolate_req || isolate_done;

  // No new requests while isolated or at the outstanding limit
  assign block_req = isolated || count_full;

  // Request path, combinational in both directions
  assign dn.req_valid = up.req_valid && !block_req;
  assign up.req_ready = dn.req_ready && !block_req;
  assign dn.req       = up.req;

  // Response path
  // While isolated, drain everything downstream and show nothing upstream
  assign up.rsp_valid = dn.rsp_valid && !isolated;
  assign dn.rsp_ready = up.rsp_ready || isolated;
  assign up.rsp       = dn.rsp;
  assign up.rsp_last  = rsp_last;

  // Done sets one cycle after the request
  // Clears only once the request is withdrawn and nothing is owed
  always_comb begin
    if (isolate_done) begin
      isolate_done_next = isolate_req || (out_count != '0);
    end else begin
      isolate_done_next = isolate_req;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      isolate_done <= 1'b0;
    end else begin
      isolate_done <= isolate_done_next;
    end
  end

endmodule

/* rtl/iso_bridge.sv */
// AXI manager port isolation bridge
`timescale 1ns/100ps
`include "iso_defines.svh"

module iso_bridge
  import iso_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       isolate_req,
  output logic                       isolate_done,

  // Upstream write address and response
  input  logic                       up_aw_valid,
  output logic                       up_aw_ready,
  input  logic [`ISO_ADDR_WIDTH-1:0] up_aw_addr,
  input  logic [`ISO_ID_WIDTH-1:0]   up_aw_id,
  output logic                       up_b_valid,
  input  logic                       up_b_ready,
  output logic [`ISO_ID_WIDTH-1:0]   up_b_id,
  output logic [1:0]                 up_b_resp,

  // Downstream write address and response
  output logic                       dn_aw_valid,
  input  logic                       dn_aw_ready,
  output logic [`ISO_ADDR_WIDTH-1:0] dn_aw_addr,
  output logic [`ISO_ID_WIDTH-1:0]   dn_aw_id,
  input  logic                       dn_b_valid,
  output logic                       dn_b_ready,
  input  logic [`ISO_ID_WIDTH-1:0]   dn_b_id,
  input  logic [1:0]                 dn_b_resp,

  // Upstream read address and data
  input  logic                       up_ar_valid,
  output logic                       up_ar_ready,
  input  logic [`ISO_ADDR_WIDTH-1:0] up_ar_addr,
  input  logic [`ISO_ID_WIDTH-1:0]   up_ar_id,
  input  logic [`ISO_LEN_WIDTH-1:0]  up_ar_len,
  output logic                       up_r_valid,
  input  logic                       up_r_ready,
  output logic [`ISO_DATA_WIDTH-1:0] up_r_data,
  output logic [`ISO_ID_WIDTH-1:0]   up_r_id,
  output logic [1:0]                 up_r_resp,
  output logic                       up_r_last,

  // Downstream read address and data
  output logic                       dn_ar_valid,
  input  logic                       dn_ar_ready,
  output logic [`ISO_ADDR_WIDTH-1:0] dn_ar_addr,
  output logic [`ISO_ID_WIDTH-1:0]   dn_ar_id,
  output logic [`ISO_LEN_WIDTH-1:0]  dn_ar_len,
  input  logic                       dn_r_valid,
  output logic                       dn_r_ready,
  input  logic [`ISO_DATA_WIDTH-1:0] dn_r_data,
  input  logic [`ISO_ID_WIDTH-1:0]   dn_r_id,
  input  logic [1:0]                 dn_r_resp,
  input  logic                       dn_r_last
);

  logic wr_isolate_done;
  logic rd_isolate_done;

  iso_chan_if #(.req_t(aw_req_t), .rsp_t(b_rsp_t)) aw_up ();
  iso_chan_if #(.req_t(aw_req_t), .rsp_t(b_rsp_t)) aw_dn ();
  iso_chan_if #(.req_t(ar_req_t), .rsp_t(r_rsp_t)) ar_up ();
  iso_chan_if #(.req_t(ar_req_t), .rsp_t(r_rsp_t)) ar_dn ();

  // Write path, upstream side
  assign aw_up.req_valid = up_aw_valid;
  assign aw_up.req       = '{addr: up_aw_addr, id: up_aw_id};
  assign up_aw_ready     = aw_up.req_ready;
  assign up_b_valid      = aw_up.rsp_valid;
  assign aw_up.rsp_ready = up_b_ready;
  assign up_b_id         = aw_up.rsp.id;
  assign up_b_resp       = aw_up.rsp.resp;

  // Write path, downstream side
  assign dn_aw_valid     = aw_dn.req_valid;
  assign aw_dn.req_ready = dn_aw_ready;
  assign dn_aw_addr      = aw_dn.req.addr;
  assign dn_aw_id        = aw_dn.req.id;
  assign aw_dn.rsp_valid = dn_b_valid;
  assign dn_b_ready      = aw_dn.rsp_ready;
  assign aw_dn.rsp       = '{id: dn_b_id, resp: dn_b_resp};
  // B has no burst, each response is its own last beat
  assign aw_dn.rsp_last  = 1'b1;

  // Read path, upstream side
  assign ar_up.req_valid = up_ar_valid;
  assign ar_up.req       = '{addr: up_ar_addr, id: up_ar_id, len: up_ar_len};
  assign up_ar_ready     = ar_up.req_ready;
  assign up_r_valid      = ar_up.rsp_valid;
  assign ar_up.rsp_ready = up_r_ready;
  assign up_r_data       = ar_up.rsp.data;
  assign up_r_id         = ar_up.rsp.id;
  assign up_r_resp       = ar_up.rsp.resp;
  assign up_r_last       = ar_up.rsp_last;

  // Read path, downstream side
  assign dn_ar_valid     = ar_dn.req_valid;
  assign ar_dn.req_ready = dn_ar_ready;
  assign dn_ar_addr      = ar_dn.req.addr;
  assign dn_ar_id        = ar_dn.req.id;
  assign dn_ar_len       = ar_dn.req.len;
  assign ar_dn.rsp_valid = dn_r_valid;
  assign dn_r_ready      = ar_dn.rsp_ready;
  assign ar_dn.rsp       = '{data: dn_r_data, id: dn_r_id, resp: dn_r_resp};
  assign ar_dn.rsp_last  = dn_r_last;

  // One response per write request
  iso_req_tracker #(
    .req_t          (aw_req_t),
    .rsp_t          (b_rsp_t),
    .MaxOutstanding (`ISO_MAX_OUTSTANDING),
    .MultiBeat      (1'b0)
  ) wr_tracker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .up           (aw_up.up),
    .dn           (aw_dn.dn),
    .isolate_req  (isolate_req),
    .isolate_done (wr_isolate_done)
  );

  // Read bursts retire on the last beat
  iso_req_tracker #(
    .req_t          (ar_req_t),
    .rsp_t          (r_rsp_t),
    .MaxOutstanding (`ISO_MAX_OUTSTANDING),
    .MultiBeat      (1'b1)
  ) rd_tracker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .up           (ar_up.up),
    .dn           (ar_dn.dn),
    .isolate_req  (isolate_req),
    .isolate_done (rd_isolate_done)
  );

  // Port counts as isolated only while both paths are
  // Both set on the same edge, so the rise is still one cycle after the request
  assign isolate_done = wr_isolate_done && rd_isolate_done;

endmodule

/* tests/iso_bridge_tb.sv */
// Isolation bridge testbench
`timescale 1ns/100ps
`include "iso_defines.svh"

module iso_bridge_tb;

  localparam int          Max          = `ISO_MAX_OUTSTANDING;
  localparam int          RunCycles    = 6000;
  localparam int          DrainTimeout = 2000;
  localparam logic [31:0] Seed         = 32'h9d6b_bfcd;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       isolate_req;
  logic                       isolate_done;
  logic                       up_aw_valid, up_aw_ready, up_b_valid, up_b_ready;
  logic [`ISO_ADDR_WIDTH-1:0] up_aw_addr, dn_aw_addr, up_ar_addr, dn_ar_addr;
  logic [`ISO_ID_WIDTH-1:0]   up_aw_id, up_b_id, dn_aw_id, dn_b_id;
  logic [1:0]                 up_b_resp, dn_b_resp, up_r_resp, dn_r_resp;
  logic                       dn_aw_valid, dn_aw_ready, dn_b_valid, dn_b_ready;
  logic                       up_ar_valid, up_ar_ready, up_r_valid, up_r_ready, up_r_last;
  logic [`ISO_ID_WIDTH-1:0]   up_ar_id, up_r_id, dn_ar_id, dn_r_id;
  logic [`ISO_LEN_WIDTH-1:0]  up_ar_len, dn_ar_len;
  logic [`ISO_DATA_WIDTH-1:0] up_r_data, dn_r_data;
  logic                       dn_ar_valid, dn_ar_ready, dn_r_valid, dn_r_ready, dn_r_last;

  // Reference model, index 0 is write, 1 is read
  int  m_count [2];
  bit  m_done [2];
  // Downstream responder queues, requests awaiting a response
  logic [`ISO_ID_WIDTH-1:0]                  wr_q [$];
  logic [`ISO_ID_WIDTH+`ISO_LEN_WIDTH-1:0]   rd_q [$];
  int                                        rd_beat;
  // Expected upstream responses, B is {id, resp}, R is {data, id, resp, last}
  logic [5:0]                                exp_b [$];
  logic [38:0]                               exp_r [$];
  // Handshakes seen on the last edge
  bit  aw_taken, ar_taken, b_taken, r_taken;
  bit  traffic_on;
  bit  hold_rsp;
  bit  prev_req;
  bit  req_rose;
  int  iso_count;
  int  full_count;

  iso_bridge iso_bridge_i (.*);

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", msg);
  endtask

  // Runs at posedge, all DUT outputs still hold their pre-edge values
  task automatic sample_and_check();
    bit         iso_w;
    bit         iso_r;
    bit         b_fire;
    bit         r_fire;
    bit         aw_fire;
    bit         ar_fire;
    bit         next_w;
    bit         next_r;
    logic [5:0]  b_exp;
    logic [38:0] r_exp;
    iso_w = isolate_req || m_done[0];
    iso_r = isolate_req || m_done[1];
    // Isolate protocol, driven by this testbench and checked here
    if (isolate_req && !prev_req && isolate_done)
      report_error("isolate_req rose while isolate_done was high");
    if (!isolate_req && prev_req && !isolate_done)
      report_error("isolate_req fell while isolate_done was low");
    // Done must follow the request by exactly one cycle
    if (req_rose) check_value("isolate_done", 1, isolate_done);
    check_value("isolate_done", m_done[0] && m_done[1], isolate_done);
    req_rose = isolate_req && !prev_req;
    prev_req = isolate_req;

    // Write path gating
    if (iso_w) begin
      check_value("dn_aw_valid", 0, dn_aw_valid);
      check_value("up_aw_ready", 0, up_aw_ready);
      check_value("up_b_valid", 0, up_b_valid);
      check_value("dn_b_ready", 1, dn_b_ready);
    end else begin
      if (m_count[0] == Max) begin
        full_count++;
        check_value("dn_aw_valid", 0, dn_aw_valid);
        check_value("up_aw_ready", 0, up_aw_ready);
      end else begin
        check_value("dn_aw_valid", up_aw_valid, dn_aw_valid);
        check_value("up_aw_ready", dn_aw_ready, up_aw_ready);
      end
      check_value("up_b_valid", dn_b_valid, up_b_valid);
      check_value("dn_b_ready", up_b_ready, dn_b_ready);
    end
    if (dn_aw_valid) begin
      check_value("dn_aw_addr", up_aw_addr, dn_aw_addr);
      check_value("dn_aw_id", up_aw_id, dn_aw_id);
    end

    // Read path gating
    if (iso_r) begin
      check_value("dn_ar_valid", 0, dn_ar_valid);
      check_value("up_ar_ready", 0, up_ar_ready);
      check_value("up_r_valid", 0, up_r_valid);
      check_value("dn_r_ready", 1, dn_r_ready);
    end else begin
      if (m_count[1] == Max) begin
        full_count++;
        check_value("dn_ar_valid", 0, dn_ar_valid);
        check_value("up_ar_ready", 0, up_ar_ready);
      end else begin
        check_value("dn_ar_valid", up_ar_valid, dn_ar_valid);
        check_value("up_ar_ready", dn_ar_ready, up_ar_ready);
      end
      check_value("up_r_valid", dn_r_valid, up_r_valid);
      check_value("dn_r_ready", up_r_ready, dn_r_ready);
    end
    if (dn_ar_valid) begin
      check_value("dn_ar_addr", up_ar_addr, dn_ar_addr);
      check_value("dn_ar_id", up_ar_id, dn_ar_id);
      check_value("dn_ar_len", up_ar_len, dn_ar_len);
    end

    // Handshakes, upstream and downstream requests move together
    aw_fire = dn_aw_valid && dn_aw_ready;
    ar_fire = dn_ar_valid && dn_ar_ready;
    b_fire  = dn_b_valid && dn_b_ready;
    r_fire  = dn_r_valid && dn_r_ready;
    check_value("up_aw handshake", aw_fire, up_aw_valid && up_aw_ready);
    check_value("up_ar handshake", ar_fire, up_ar_valid && up_ar_ready);
    if (aw_fire) wr_q.push_back(dn_aw_id);
    if (ar_fire) rd_q.push_back({dn_ar_id, dn_ar_len});

    // Responses forwarded only outside isolation
    if (b_fire && !iso_w) exp_b.push_back({dn_b_id, dn_b_resp});
    if (r_fire && !iso_r) exp_r.push_back({dn_r_data, dn_r_id, dn_r_resp, dn_r_last});
    if (up_b_valid && up_b_ready) begin
      b_exp = exp_b.pop_front();
      check_value("up_b_id", b_exp[5:2], up_b_id);
      check_value("up_b_resp", b_exp[1:0], up_b_resp);
    end
    if (up_r_valid && up_r_ready) begin
      r_exp = exp_r.pop_front();
      check_value("up_r_data", r_exp[38:7], up_r_data);
      check_value("up_r_id", r_exp[6:3], up_r_id);
      check_value("up_r_resp", r_exp[2:1], up_r_resp);
      check_value("up_r_last", r_exp[0], up_r_last);
    end

    // Responder bookkeeping
    if (b_fire) void'(wr_q.pop_front());
    if (r_fire) begin
      if (dn_r_last) begin
        void'(rd_q.pop_front());
        rd_beat = 0;
      end else begin
        rd_beat++;
      end
    end

    // Done register per path uses the count from before this edge
    next_w = isolate_req || (m_done[0] && m_count[0] != 0);
    next_r = isolate_req || (m_done[1] && m_count[1] != 0);
    m_done[0] = next_w;
    m_done[1] = next_r;
    m_count[0] = m_count[0] + int'(aw_fire) - int'(b_fire);
    m_count[1] = m_count[1] + int'(ar_fire) - int'(r_fire && dn_r_last);
    aw_taken = aw_fire;
    ar_taken = ar_fire;
    b_taken  = b_fire;
    r_taken  = r_fire;
  endtask

  // Runs at negedge
  task automatic drive_inputs();
    // Upstream requests stay up until accepted
    if (!up_aw_valid || aw_taken) begin
      up_aw_valid = traffic_on && ($urandom_range(2) == 0);
      up_aw_addr  = $urandom;
      up_aw_id    = $urandom;
    end
    if (!up_ar_valid || ar_taken) begin
      up_ar_valid = traffic_on && ($urandom_range(2) == 0);
      up_ar_addr  = $urandom;
      up_ar_id    = $urandom;
      up_ar_len   = $urandom_range(15);
    end
    up_b_ready  = $urandom_range(3) != 0;
    up_r_ready  = $urandom_range(3) != 0;
    dn_aw_ready = $urandom_range(3) != 0;
    dn_ar_ready = $urandom_range(3) != 0;

    // Occasional response stall lets the outstanding limit fill
    if (!traffic_on) hold_rsp = 1'b0;
    else if ($urandom_range(59) == 0) hold_rsp = !hold_rsp;

    // Downstream B, one per write request, in order
    if (b_taken) dn_b_valid = 1'b0;
    if (!dn_b_valid && wr_q.size() > 0 && !hold_rsp && $urandom_range(2) == 0) begin
      dn_b_valid = 1'b1;
      dn_b_id    = wr_q[0];
      dn_b_resp  = $urandom;
    end
    // Downstream R, len+1 beats per read request
    if (r_taken) dn_r_valid = 1'b0;
    if (!dn_r_valid && rd_q.size() > 0 && !hold_rsp && $urandom_range(1) == 0) begin
      dn_r_valid = 1'b1;
      dn_r_id    = rd_q[0][`ISO_LEN_WIDTH +: `ISO_ID_WIDTH];
      dn_r_data  = $urandom;
      dn_r_resp  = $urandom;
      dn_r_last  = (rd_beat == int'(rd_q[0][`ISO_LEN_WIDTH-1:0]));
    end

    // Isolate requests obey the rise and fall protocol
    if (!isolate_req && !isolate_done && traffic_on && $urandom_range(79) == 0) begin
      isolate_req = 1'b1;
      iso_count++;
    end else if (isolate_req && isolate_done && (!traffic_on || $urandom_range(7) == 0)) begin
      isolate_req = 1'b0;
    end
  endtask

  task automatic advance_cycle();
    @(posedge clk);
    sample_and_check();
    @(negedge clk);
    drive_inputs();
  endtask

  function automatic bit is_drained();
    return !isolate_req && !isolate_done && !up_aw_valid && !up_ar_valid
           && m_count[0] == 0 && m_count[1] == 0 && wr_q.size() == 0 && rd_q.size() == 0;
  endfunction

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (!is_drained() && cycles < DrainTimeout) begin
      advance_cycle();
      cycles++;
    end
    if (!is_drained()) report_error("timeout waiting for outstanding requests to drain");
  endtask

  initial begin
    void'($urandom(Seed));
    rst_n       = 1'b0;
    isolate_req = 1'b0;
    up_aw_valid = 1'b0;
    up_aw_addr  = '0;
    up_aw_id    = '0;
    up_b_ready  = 1'b0;
    dn_aw_ready = 1'b0;
    dn_b_valid  = 1'b0;
    dn_b_id     = '0;
    dn_b_resp   = '0;
    up_ar_valid = 1'b0;
    up_ar_addr  = '0;
    up_ar_id    = '0;
    up_ar_len   = '0;
    up_r_ready  = 1'b0;
    dn_ar_ready = 1'b0;
    dn_r_valid  = 1'b0;
    dn_r_data   = '0;
    dn_r_id     = '0;
    dn_r_resp   = '0;
    dn_r_last   = 1'b0;
    m_count     = '{0, 0};
    m_done      = '{0, 0};
    rd_beat     = 0;
    traffic_on  = 1'b0;
    hold_rsp    = 1'b0;
    prev_req    = 1'b0;
    req_rose    = 1'b0;
    iso_count   = 0;
    full_count  = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet bridge straight out of reset
    check_value("isolate_done", 0, isolate_done);
    check_value("dn_aw_valid", 0, dn_aw_valid);
    check_value("dn_ar_valid", 0, dn_ar_valid);
    check_value("up_b_valid", 0, up_b_valid);
    check_value("up_r_valid", 0, up_r_valid);
    traffic_on = 1'b1;
    repeat (RunCycles) advance_cycle();
    traffic_on = 1'b0;
    wait_drained();
    $display("Isolation episodes %0d, cycles at limit %0d", iso_count, full_count);
    if (iso_count == 0 || full_count == 0) begin
      report_error("random traffic never reached isolation or the outstanding limit");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

/* sim.f */
+incdir+rtl
rtl/iso_pkg.sv
rtl/iso_chan_if.sv
rtl/outstanding_counter.sv
rtl/iso_req_tracker.sv
rtl/iso_bridge.sv
tests/iso_bridge_tb.sv

/* Bender.yml */
package:
  name: iso_bridge

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/iso_pkg.sv
      - rtl/iso_chan_if.sv
      - rtl/outstanding_counter.sv
      - rtl/iso_req_tracker.sv
      - rtl/iso_bridge.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/iso_bridge_tb.sv
